// File: verilog/eth_frame_pkg.sv
/* Ethernet frame definitions
   Field widths, ethertypes and the packed header and payload beat */
package eth_frame_pkg;

    localparam int MAC_W  = 48;
    localparam int TYPE_W = 16;
    localparam int DATA_W = 64;
    localparam int KEEP_W = DATA_W / 8;

    // Ethertypes that have a sink of their own
    localparam logic [TYPE_W-1:0] ETHERTYPE_IPV4 = 16'h0800;
    localparam logic [TYPE_W-1:0] ETHERTYPE_ARP  = 16'h0806;

    // Frame header as it travels on the header channel, 112 bits
    typedef struct packed {
        logic [MAC_W-1:0]  dest_mac;
        logic [MAC_W-1:0]  src_mac;
        logic [TYPE_W-1:0] eth_type;
    } eth_hdr_t;

    // One payload beat, 74 bits
    typedef struct packed {
        logic [DATA_W-1:0] tdata;
        logic [KEEP_W-1:0] tkeep;
        logic              tlast;
        logic              tuser;
    } eth_beat_t;

endpackage

// File: verilog/eth_route_pkg.sv
/* Routing state encodings
   Receive frame destination and transmit output owner */
package eth_route_pkg;

    // Destination of the receive frame in flight
    typedef enum logic [1:0] {
        ROUTE_IDLE = 2'd0,
        ROUTE_IP   = 2'd1,
        ROUTE_ARP  = 2'd2,
        ROUTE_DROP = 2'd3
    } route_t;

    // Source that currently owns the transmit output
    typedef enum logic [1:0] {
        SRC_NONE = 2'd0,
        SRC_ARP  = 2'd1,
        SRC_IP   = 2'd2
    } tx_src_t;

endpackage

// File: verilog/eth_skid_buffer.sv
/* Skid buffer
   Two-entry valid/ready register slice for any payload type */
module eth_skid_buffer #(
    parameter type T = logic
) (
    input  logic clk,
    input  logic rst,

    input  logic in_valid,
    input  T     in_data,
    output logic in_ready,

    output logic out_valid,
    output T     out_data,
    input  logic out_ready
);

    logic out_valid_q;
    logic skid_valid_q;
    T     out_data_q;
    T     skid_data_q;
    logic load_out;
    logic in_fire;

    // Output slot can take a new item when empty or draining
    assign load_out = out_ready || !out_valid_q;
    assign in_fire  = in_valid && in_ready;
    assign in_ready = !skid_valid_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid_q  <= 1'b0;
            skid_valid_q <= 1'b0;
        end else if (load_out) begin
            out_valid_q  <= skid_valid_q || in_fire;
            skid_valid_q <= 1'b0;
        end else if (in_fire) begin
            skid_valid_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (load_out) begin
            out_data_q <= skid_valid_q ? skid_data_q : in_data;
        end
        // Stalled output parks the incoming item
        if (in_fire && !load_out) begin
            skid_data_q <= in_data;
        end
    end

    assign out_valid = out_valid_q;
    assign out_data  = out_data_q;

endmodule

// File: verilog/eth_rx_classifier.sv
/* Ethernet receive classifier
   Steers each frame to the IP or ARP sink by ethertype, or drains it */
module eth_rx_classifier
    import eth_frame_pkg::*, eth_route_pkg::*;
(
    input  logic              clk,
    input  logic              rst,

    input  logic              rx_hdr_valid,
    output logic              rx_hdr_ready,
    input  logic [MAC_W-1:0]  rx_dest_mac,
    input  logic [MAC_W-1:0]  rx_src_mac,
    input  logic [TYPE_W-1:0] rx_eth_type,
    input  logic [DATA_W-1:0] rx_tdata,
    input  logic [KEEP_W-1:0] rx_tkeep,
    input  logic              rx_tvalid,
    output logic              rx_tready,
    input  logic              rx_tlast,
    input  logic              rx_tuser,

    output logic              ip_hdr_valid,
    input  logic              ip_hdr_ready,
    output logic [MAC_W-1:0]  ip_dest_mac,
    output logic [MAC_W-1:0]  ip_src_mac,
    output logic [DATA_W-1:0] ip_tdata,
    output logic [KEEP_W-1:0] ip_tkeep,
    output logic              ip_tvalid,
    input  logic              ip_tready,
    output logic              ip_tlast,
    output logic              ip_tuser,

    output logic              arp_hdr_valid,
    input  logic              arp_hdr_ready,
    output logic [MAC_W-1:0]  arp_dest_mac,
    output logic [MAC_W-1:0]  arp_src_mac,
    output logic [DATA_W-1:0] arp_tdata,
    output logic [KEEP_W-1:0] arp_tkeep,
    output logic              arp_tvalid,
    input  logic              arp_tready,
    output logic              arp_tlast,
    output logic              arp_tuser
);

    route_t route_q;
    route_t hdr_route;
    logic   idle;

    // Decode of the waiting header
    assign hdr_route = (rx_eth_type == ETHERTYPE_IPV4) ? ROUTE_IP :
                       (rx_eth_type == ETHERTYPE_ARP)  ? ROUTE_ARP : ROUTE_DROP;
    assign idle = (route_q == ROUTE_IDLE);

    assign ip_hdr_valid  = idle && rx_hdr_valid && (hdr_route == ROUTE_IP);
    assign arp_hdr_valid = idle && rx_hdr_valid && (hdr_route == ROUTE_ARP);

    always_comb begin
        rx_hdr_ready = 1'b0;
        if (idle) begin
            case (hdr_route)
                ROUTE_IP:  rx_hdr_ready = ip_hdr_ready;
                ROUTE_ARP: rx_hdr_ready = arp_hdr_ready;
                default:   rx_hdr_ready = 1'b1;
            endcase
        end
    end

    // Payload follows the registered route; dropped beats are taken at once
    assign ip_tvalid  = (route_q == ROUTE_IP) && rx_tvalid;
    assign arp_tvalid = (route_q == ROUTE_ARP) && rx_tvalid;

    always_comb begin
        case (route_q)
            ROUTE_IP:   rx_tready = ip_tready;
            ROUTE_ARP:  rx_tready = arp_tready;
            ROUTE_DROP: rx_tready = 1'b1;
            default:    rx_tready = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            route_q <= ROUTE_IDLE;
        end else if (idle && rx_hdr_valid && rx_hdr_ready) begin
            route_q <= hdr_route;
        end else if (rx_tvalid && rx_tready && rx_tlast) begin
            route_q <= ROUTE_IDLE;
        end
    end

    // Fields fan out to both sinks, valid decides who sees them
    assign ip_dest_mac  = rx_dest_mac;
    assign ip_src_mac   = rx_src_mac;
    assign ip_tdata     = rx_tdata;
    assign ip_tkeep     = rx_tkeep;
    assign ip_tlast     = rx_tlast;
    assign ip_tuser     = rx_tuser;
    assign arp_dest_mac = rx_dest_mac;
    assign arp_src_mac  = rx_src_mac;
    assign arp_tdata    = rx_tdata;
    assign arp_tkeep    = rx_tkeep;
    assign arp_tlast    = rx_tlast;
    assign arp_tuser    = rx_tuser;

endmodule

// File: verilog/eth_tx_arbiter.sv
/* Ethernet transmit arbiter
   Merges ARP and IP frames, ARP first, granting whole frames */
module eth_tx_arbiter
    import eth_frame_pkg::*, eth_route_pkg::*;
(
    input  logic              clk,
    input  logic              rst,

    input  logic              arp_hdr_valid,
    output logic              arp_hdr_ready,
    input  logic [MAC_W-1:0]  arp_dest_mac,
    input  logic [MAC_W-1:0]  arp_src_mac,
    input  logic [TYPE_W-1:0] arp_eth_type,
    input  logic [DATA_W-1:0] arp_tdata,
    input  logic [KEEP_W-1:0] arp_tkeep,
    input  logic              arp_tvalid,
    output logic              arp_tready,
    input  logic              arp_tlast,
    input  logic              arp_tuser,

    input  logic              ip_hdr_valid,
    output logic              ip_hdr_ready,
    input  logic [MAC_W-1:0]  ip_dest_mac,
    input  logic [MAC_W-1:0]  ip_src_mac,
    input  logic [TYPE_W-1:0] ip_eth_type,
    input  logic [DATA_W-1:0] ip_tdata,
    input  logic [KEEP_W-1:0] ip_tkeep,
    input  logic              ip_tvalid,
    output logic              ip_tready,
    input  logic              ip_tlast,
    input  logic              ip_tuser,

    output logic              out_hdr_valid,
    output eth_hdr_t          out_hdr,
    input  logic              out_hdr_ready,
    output logic              out_beat_valid,
    output eth_beat_t         out_beat,
    input  logic              out_beat_ready
);

    tx_src_t src_q;
    logic    hdr_done_q;
    logic    sel_arp;
    logic    sel_ip;
    logic    hdr_fire;
    logic    beat_fire;

    assign sel_arp = (src_q == SRC_ARP);
    assign sel_ip  = (src_q == SRC_IP);

    // Header goes first, then the beats of the same frame
    assign out_hdr_valid  = !hdr_done_q && ((sel_arp && arp_hdr_valid) ||
                                            (sel_ip && ip_hdr_valid));
    assign out_beat_valid = hdr_done_q && ((sel_arp && arp_tvalid) ||
                                           (sel_ip && ip_tvalid));

    assign out_hdr.dest_mac = sel_arp ? arp_dest_mac : ip_dest_mac;
    assign out_hdr.src_mac  = sel_arp ? arp_src_mac : ip_src_mac;
    assign out_hdr.eth_type = sel_arp ? arp_eth_type : ip_eth_type;

    assign out_beat.tdata = sel_arp ? arp_tdata : ip_tdata;
    assign out_beat.tkeep = sel_arp ? arp_tkeep : ip_tkeep;
    assign out_beat.tlast = sel_arp ? arp_tlast : ip_tlast;
    assign out_beat.tuser = sel_arp ? arp_tuser : ip_tuser;

    // Loser sees ready low
    assign arp_hdr_ready = sel_arp && !hdr_done_q && out_hdr_ready;
    assign ip_hdr_ready  = sel_ip && !hdr_done_q && out_hdr_ready;
    assign arp_tready    = sel_arp && hdr_done_q && out_beat_ready;
    assign ip_tready     = sel_ip && hdr_done_q && out_beat_ready;

    assign hdr_fire  = out_hdr_valid && out_hdr_ready;
    assign beat_fire = out_beat_valid && out_beat_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            src_q      <= SRC_NONE;
            hdr_done_q <= 1'b0;
        end else if (src_q == SRC_NONE) begin
            // Fixed priority grant
            if (arp_hdr_valid) begin
                src_q <= SRC_ARP;
            end else if (ip_hdr_valid) begin
                src_q <= SRC_IP;
            end
        end else if (hdr_fire) begin
            hdr_done_q <= 1'b1;
        end else if (beat_fire && out_beat.tlast) begin
            src_q      <= SRC_NONE;
            hdr_done_q <= 1'b0;
        end
    end

endmodule

// File: verilog/eth_type_switch.sv
/* Ethernet type switch
   Joins the receive classifier, the transmit arbiter and output buffers */
module eth_type_switch
    import eth_frame_pkg::*;
(
    input  logic              clk,
    input  logic              rst,

    input  logic              rx_hdr_valid,
    output logic              rx_hdr_ready,
    input  logic [MAC_W-1:0]  rx_dest_mac,
    input  logic [MAC_W-1:0]  rx_src_mac,
    input  logic [TYPE_W-1:0] rx_eth_type,
    input  logic [DATA_W-1:0] rx_payload_tdata,
    input  logic [KEEP_W-1:0] rx_payload_tkeep,
    input  logic              rx_payload_tvalid,
    output logic              rx_payload_tready,
    input  logic              rx_payload_tlast,
    input  logic              rx_payload_tuser,

    output logic              ip_rx_hdr_valid,
    input  logic              ip_rx_hdr_ready,
    output logic [MAC_W-1:0]  ip_rx_dest_mac,
    output logic [MAC_W-1:0]  ip_rx_src_mac,
    output logic [DATA_W-1:0] ip_rx_payload_tdata,
    output logic [KEEP_W-1:0] ip_rx_payload_tkeep,
    output logic              ip_rx_payload_tvalid,
    input  logic              ip_rx_payload_tready,
    output logic              ip_rx_payload_tlast,
    output logic              ip_rx_payload_tuser,

    output logic              arp_rx_hdr_valid,
    input  logic              arp_rx_hdr_ready,
    output logic [MAC_W-1:0]  arp_rx_dest_mac,
    output logic [MAC_W-1:0]  arp_rx_src_mac,
    output logic [DATA_W-1:0] arp_rx_payload_tdata,
    output logic [KEEP_W-1:0] arp_rx_payload_tkeep,
    output logic              arp_rx_payload_tvalid,
    input  logic              arp_rx_payload_tready,
    output logic              arp_rx_payload_tlast,
    output logic              arp_rx_payload_tuser,

    input  logic              arp_tx_hdr_valid,
    output logic              arp_tx_hdr_ready,
    input  logic [MAC_W-1:0]  arp_tx_dest_mac,
    input  logic [MAC_W-1:0]  arp_tx_src_mac,
    input  logic [TYPE_W-1:0] arp_tx_eth_type,
    input  logic [DATA_W-1:0] arp_tx_payload_tdata,
    input  logic [KEEP_W-1:0] arp_tx_payload_tkeep,
    input  logic              arp_tx_payload_tvalid,
    output logic              arp_tx_payload_tready,
    input  logic              arp_tx_payload_tlast,
    input  logic              arp_tx_payload_tuser,

    input  logic              ip_tx_hdr_valid,
    output logic              ip_tx_hdr_ready,
    input  logic [MAC_W-1:0]  ip_tx_dest_mac,
    input  logic [MAC_W-1:0]  ip_tx_src_mac,
    input  logic [TYPE_W-1:0] ip_tx_eth_type,
    input  logic [DATA_W-1:0] ip_tx_payload_tdata,
    input  logic [KEEP_W-1:0] ip_tx_payload_tkeep,
    input  logic              ip_tx_payload_tvalid,
    output logic              ip_tx_payload_tready,
    input  logic              ip_tx_payload_tlast,
    input  logic              ip_tx_payload_tuser,

    output logic              tx_hdr_valid,
    input  logic              tx_hdr_ready,
    output logic [MAC_W-1:0]  tx_dest_mac,
    output logic [MAC_W-1:0]  tx_src_mac,
    output logic [TYPE_W-1:0] tx_eth_type,
    output logic [DATA_W-1:0] tx_payload_tdata,
    output logic [KEEP_W-1:0] tx_payload_tkeep,
    output logic              tx_payload_tvalid,
    input  logic              tx_payload_tready,
    output logic              tx_payload_tlast,
    output logic              tx_payload_tuser
);

    // Arbiter to buffer
    logic      arb_hdr_valid;
    logic      arb_hdr_ready;
    eth_hdr_t  arb_hdr;
    logic      arb_beat_valid;
    logic      arb_beat_ready;
    eth_beat_t arb_beat;

    // Buffer outputs before unpacking
    eth_hdr_t  buf_hdr;
    eth_beat_t buf_beat;

    eth_rx_classifier rx_classifier (
        .clk           (clk),
        .rst           (rst),
        .rx_hdr_valid  (rx_hdr_valid),
        .rx_hdr_ready  (rx_hdr_ready),
        .rx_dest_mac   (rx_dest_mac),
        .rx_src_mac    (rx_src_mac),
        .rx_eth_type   (rx_eth_type),
        .rx_tdata      (rx_payload_tdata),
        .rx_tkeep      (rx_payload_tkeep),
        .rx_tvalid     (rx_payload_tvalid),
        .rx_tready     (rx_payload_tready),
        .rx_tlast      (rx_payload_tlast),
        .rx_tuser      (rx_payload_tuser),
        .ip_hdr_valid  (ip_rx_hdr_valid),
        .ip_hdr_ready  (ip_rx_hdr_ready),
        .ip_dest_mac   (ip_rx_dest_mac),
        .ip_src_mac    (ip_rx_src_mac),
        .ip_tdata      (ip_rx_payload_tdata),
        .ip_tkeep      (ip_rx_payload_tkeep),
        .ip_tvalid     (ip_rx_payload_tvalid),
        .ip_tready     (ip_rx_payload_tready),
        .ip_tlast      (ip_rx_payload_tlast),
        .ip_tuser      (ip_rx_payload_tuser),
        .arp_hdr_valid (arp_rx_hdr_valid),
        .arp_hdr_ready (arp_rx_hdr_ready),
        .arp_dest_mac  (arp_rx_dest_mac),
        .arp_src_mac   (arp_rx_src_mac),
        .arp_tdata     (arp_rx_payload_tdata),
        .arp_tkeep     (arp_rx_payload_tkeep),
        .arp_tvalid    (arp_rx_payload_tvalid),
        .arp_tready    (arp_rx_payload_tready),
        .arp_tlast     (arp_rx_payload_tlast),
        .arp_tuser     (arp_rx_payload_tuser)
    );

    // ARP has priority over IP
    eth_tx_arbiter tx_arbiter (
        .clk            (clk),
        .rst            (rst),
        .arp_hdr_valid  (arp_tx_hdr_valid),
        .arp_hdr_ready  (arp_tx_hdr_ready),
        .arp_dest_mac   (arp_tx_dest_mac),
        .arp_src_mac    (arp_tx_src_mac),
        .arp_eth_type   (arp_tx_eth_type),
        .arp_tdata      (arp_tx_payload_tdata),
        .arp_tkeep      (arp_tx_payload_tkeep),
        .arp_tvalid     (arp_tx_payload_tvalid),
        .arp_tready     (arp_tx_payload_tready),
        .arp_tlast      (arp_tx_payload_tlast),
        .arp_tuser      (arp_tx_payload_tuser),
        .ip_hdr_valid   (ip_tx_hdr_valid),
        .ip_hdr_ready   (ip_tx_hdr_ready),
        .ip_dest_mac    (ip_tx_dest_mac),
        .ip_src_mac     (ip_tx_src_mac),
        .ip_eth_type    (ip_tx_eth_type),
        .ip_tdata       (ip_tx_payload_tdata),
        .ip_tkeep       (ip_tx_payload_tkeep),
        .ip_tvalid      (ip_tx_payload_tvalid),
        .ip_tready      (ip_tx_payload_tready),
        .ip_tlast       (ip_tx_payload_tlast),
        .ip_tuser       (ip_tx_payload_tuser),
        .out_hdr_valid  (arb_hdr_valid),
        .out_hdr        (arb_hdr),
        .out_hdr_ready  (arb_hdr_ready),
        .out_beat_valid (arb_beat_valid),
        .out_beat       (arb_beat),
        .out_beat_ready (arb_beat_ready)
    );

    eth_skid_buffer #(.T(eth_hdr_t)) hdr_buffer (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (arb_hdr_valid),
        .in_data   (arb_hdr),
        .in_ready  (arb_hdr_ready),
        .out_valid (tx_hdr_valid),
        .out_data  (buf_hdr),
        .out_ready (tx_hdr_ready)
    );

    eth_skid_buffer #(.T(eth_beat_t)) beat_buffer (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (arb_beat_valid),
        .in_data   (arb_beat),
        .in_ready  (arb_beat_ready),
        .out_valid (tx_payload_tvalid),
        .out_data  (buf_beat),
        .out_ready (tx_payload_tready)
    );

    assign tx_dest_mac      = buf_hdr.dest_mac;
    assign tx_src_mac       = buf_hdr.src_mac;
    assign tx_eth_type      = buf_hdr.eth_type;
    assign tx_payload_tdata = buf_beat.tdata;
    assign tx_payload_tkeep = buf_beat.tkeep;
    assign tx_payload_tlast = buf_beat.tlast;
    assign tx_payload_tuser = buf_beat.tuser;

endmodule

// File: bench/eth_type_switch_tb.sv
/* Ethernet type switch testbench
   Directed frame tests checked against queues of expected headers and beats */
module eth_type_switch_tb
    import eth_frame_pkg::*;
();

    localparam int PORT_RX     = 0;
    localparam int PORT_ARP_TX = 1;
    localparam int PORT_IP_TX  = 2;
    localparam int S_IP        = 0;
    localparam int S_ARP       = 1;
    localparam int S_TX        = 2;
    localparam int RAND_FRAMES = 12;
    localparam int MAX_LEN     = 6;
    localparam int FRAME_SLOTS = 40;
    // Directed tests carry 21 beats, a random frame at most a header and MAX_LEN beats
    localparam int TOTAL_BEATS     = 21 + 2 * RAND_FRAMES * (MAX_LEN + 1);
    localparam int WATCHDOG_CYCLES = TOTAL_BEATS * 20;

    logic clk = 1'b0;
    logic rst;

    logic              rx_hdr_valid, rx_hdr_ready, rx_payload_tvalid, rx_payload_tready;
    logic              rx_payload_tlast, rx_payload_tuser;
    logic [MAC_W-1:0]  rx_dest_mac, rx_src_mac;
    logic [TYPE_W-1:0] rx_eth_type;
    logic [DATA_W-1:0] rx_payload_tdata;
    logic [KEEP_W-1:0] rx_payload_tkeep;

    logic              ip_rx_hdr_valid, ip_rx_hdr_ready, ip_rx_payload_tvalid;
    logic              ip_rx_payload_tready, ip_rx_payload_tlast, ip_rx_payload_tuser;
    logic [MAC_W-1:0]  ip_rx_dest_mac, ip_rx_src_mac;
    logic [DATA_W-1:0] ip_rx_payload_tdata;
    logic [KEEP_W-1:0] ip_rx_payload_tkeep;

    logic              arp_rx_hdr_valid, arp_rx_hdr_ready, arp_rx_payload_tvalid;
    logic              arp_rx_payload_tready, arp_rx_payload_tlast, arp_rx_payload_tuser;
    logic [MAC_W-1:0]  arp_rx_dest_mac, arp_rx_src_mac;
    logic [DATA_W-1:0] arp_rx_payload_tdata;
    logic [KEEP_W-1:0] arp_rx_payload_tkeep;

    logic              arp_tx_hdr_valid, arp_tx_hdr_ready, arp_tx_payload_tvalid;
    logic              arp_tx_payload_tready, arp_tx_payload_tlast, arp_tx_payload_tuser;
    logic [MAC_W-1:0]  arp_tx_dest_mac, arp_tx_src_mac;
    logic [TYPE_W-1:0] arp_tx_eth_type;
    logic [DATA_W-1:0] arp_tx_payload_tdata;
    logic [KEEP_W-1:0] arp_tx_payload_tkeep;

    logic              ip_tx_hdr_valid, ip_tx_hdr_ready, ip_tx_payload_tvalid;
    logic              ip_tx_payload_tready, ip_tx_payload_tlast, ip_tx_payload_tuser;
    logic [MAC_W-1:0]  ip_tx_dest_mac, ip_tx_src_mac;
    logic [TYPE_W-1:0] ip_tx_eth_type;
    logic [DATA_W-1:0] ip_tx_payload_tdata;
    logic [KEEP_W-1:0] ip_tx_payload_tkeep;

    logic              tx_hdr_valid, tx_hdr_ready, tx_payload_tvalid, tx_payload_tready;
    logic              tx_payload_tlast, tx_payload_tuser;
    logic [MAC_W-1:0]  tx_dest_mac, tx_src_mac;
    logic [TYPE_W-1:0] tx_eth_type;
    logic [DATA_W-1:0] tx_payload_tdata;
    logic [KEEP_W-1:0] tx_payload_tkeep;

    int    seed         = 32'hbfdf;
    int    ready_seed   = 32'hbfdf;
    logic  random_ready = 1'b0;
    int    errors       = 0;
    int    checks       = 0;
    string cur_test     = "reset";
    string stream_name [3] = '{"ip_rx", "arp_rx", "tx"};

    // Frames built by the tests, sent later by index
    eth_hdr_t  f_hdr  [FRAME_SLOTS];
    int        f_len  [FRAME_SLOTS];
    eth_beat_t f_beat [FRAME_SLOTS][MAX_LEN];
    int        nf = 0;

    // Expected traffic per output stream
    eth_hdr_t  exp_hdr  [3][$];
    eth_beat_t exp_beat [3][$];

    eth_type_switch UUT (.*);

    always #50 clk = ~clk;

    // Sink and output readies, a quarter of cycles stalled while random_ready is set
    initial begin
        forever begin
            ip_rx_hdr_ready       = !random_ready || (($random(ready_seed) & 3) != 0);
            ip_rx_payload_tready  = !random_ready || (($random(ready_seed) & 3) != 0);
            arp_rx_hdr_ready      = !random_ready || (($random(ready_seed) & 3) != 0);
            arp_rx_payload_tready = !random_ready || (($random(ready_seed) & 3) != 0);
            tx_hdr_ready          = !random_ready || (($random(ready_seed) & 3) != 0);
            tx_payload_tready     = !random_ready || (($random(ready_seed) & 3) != 0);
            @(posedge clk);
            #1;
        end
    end

    function automatic void push_expected(input int s, input eth_hdr_t h, input int f);
        int i;
        exp_hdr[s].push_back(h);
        for (i = 0; i < f_len[f]; i++) begin
            exp_beat[s].push_back(f_beat[f][i]);
        end
    endfunction

    function automatic int make_frame(input logic [TYPE_W-1:0] eth_type, input int len,
                                      input int port);
        int        f;
        int        i;
        eth_hdr_t  h;
        eth_beat_t b;
        f  = nf;
        nf = nf + 1;
        h.dest_mac = {16'($random(seed)), 32'($random(seed))};
        h.src_mac  = {16'($random(seed)), 32'($random(seed))};
        h.eth_type = eth_type;
        f_hdr[f] = h;
        f_len[f] = len;
        for (i = 0; i < len; i++) begin
            b.tdata = {32'($random(seed)), 32'($random(seed))};
            b.tlast = (i == len - 1);
            b.tkeep = b.tlast ? (8'hff >> 3'($random(seed))) : 8'hff;
            b.tuser = b.tlast ? 1'($random(seed)) : 1'b0;
            f_beat[f][i] = b;
        end
        // Transmit frames all reach tx, receive frames go by ethertype
        // and sinks see no ethertype
        h.eth_type = '0;
        if (port != PORT_RX) begin
            push_expected(S_TX, f_hdr[f], f);
        end else if (eth_type == 16'h0800) begin
            push_expected(S_IP, h, f);
        end else if (eth_type == 16'h0806) begin
            push_expected(S_ARP, h, f);
        end
        return f;
    endfunction

    task automatic put_hdr(input int port, input eth_hdr_t h, input logic valid);
        case (port)
            PORT_RX: begin
                rx_hdr_valid = valid;
                rx_dest_mac  = h.dest_mac;
                rx_src_mac   = h.src_mac;
                rx_eth_type  = h.eth_type;
            end
            PORT_ARP_TX: begin
                arp_tx_hdr_valid = valid;
                arp_tx_dest_mac  = h.dest_mac;
                arp_tx_src_mac   = h.src_mac;
                arp_tx_eth_type  = h.eth_type;
            end
            default: begin
                ip_tx_hdr_valid = valid;
                ip_tx_dest_mac  = h.dest_mac;
                ip_tx_src_mac   = h.src_mac;
                ip_tx_eth_type  = h.eth_type;
            end
        endcase
    endtask

    task automatic put_beat(input int port, input eth_beat_t b, input logic valid);
        case (port)
            PORT_RX: begin
                rx_payload_tvalid = valid;
                rx_payload_tdata  = b.tdata;
                rx_payload_tkeep  = b.tkeep;
                rx_payload_tlast  = b.tlast;
                rx_payload_tuser  = b.tuser;
            end
            PORT_ARP_TX: begin
                arp_tx_payload_tvalid = valid;
                arp_tx_payload_tdata  = b.tdata;
                arp_tx_payload_tkeep  = b.tkeep;
                arp_tx_payload_tlast  = b.tlast;
                arp_tx_payload_tuser  = b.tuser;
            end
            default: begin
                ip_tx_payload_tvalid = valid;
                ip_tx_payload_tdata  = b.tdata;
                ip_tx_payload_tkeep  = b.tkeep;
                ip_tx_payload_tlast  = b.tlast;
                ip_tx_payload_tuser  = b.tuser;
            end
        endcase
    endtask

    function automatic logic hdr_ready(input int port);
        case (port)
            PORT_RX:     return rx_hdr_ready;
            PORT_ARP_TX: return arp_tx_hdr_ready;
            default:     return ip_tx_hdr_ready;
        endcase
    endfunction

    function automatic logic beat_ready(input int port);
        case (port)
            PORT_RX:     return rx_payload_tready;
            PORT_ARP_TX: return arp_tx_payload_tready;
            default:     return ip_tx_payload_tready;
        endcase
    endfunction

    // Header, then beats; each item held until the edge that takes it
    task automatic send_frame(input int port, input int f);
        int i;
        @(posedge clk);
        #1;
        put_hdr(port, f_hdr[f], 1'b1);
        @(negedge clk);
        while (!hdr_ready(port)) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        put_hdr(port, '0, 1'b0);
        for (i = 0; i < f_len[f]; i++) begin
            put_beat(port, f_beat[f][i], 1'b1);
            @(negedge clk);
            while (!beat_ready(port)) begin
                @(negedge clk);
            end
            @(posedge clk);
            #1;
        end
        put_beat(port, '0, 1'b0);
    endtask

    task automatic watch_hdr(input int s, input logic valid, input logic ready,
                             input eth_hdr_t act);
        eth_hdr_t exp;
        if (valid) begin
            assert (exp_hdr[s].size() > 0) else begin
                errors++;
                $display("Unexpected header on %s during %s", stream_name[s], cur_test);
            end
            if (ready && exp_hdr[s].size() > 0) begin
                exp = exp_hdr[s].pop_front();
                checks++;
                assert (act == exp) else begin
                    errors++;
                    $display("error %s %s header: expected %h actual %h",
                             cur_test, stream_name[s], exp, act);
                end
            end
        end
    endtask

    task automatic watch_beat(input int s, input logic valid, input logic ready,
                              input eth_beat_t act);
        eth_beat_t exp;
        if (valid) begin
            assert (exp_beat[s].size() > 0) else begin
                errors++;
                $display("Unexpected payload beat on %s during %s", stream_name[s], cur_test);
            end
            if (ready && exp_beat[s].size() > 0) begin
                exp = exp_beat[s].pop_front();
                checks++;
                assert (act == exp) else begin
                    errors++;
                    $display("error %s %s beat: expected %h actual %h",
                             cur_test, stream_name[s], exp, act);
                end
            end
        end
    endtask

    // Sampled mid-cycle, where inputs and outputs have settled
    always @(negedge clk) begin
        if (!rst) begin
            watch_hdr(S_IP, ip_rx_hdr_valid, ip_rx_hdr_ready,
                      {ip_rx_dest_mac, ip_rx_src_mac, {TYPE_W{1'b0}}});
            watch_beat(S_IP, ip_rx_payload_tvalid, ip_rx_payload_tready,
                       {ip_rx_payload_tdata, ip_rx_payload_tkeep,
                        ip_rx_payload_tlast, ip_rx_payload_tuser});
            watch_hdr(S_ARP, arp_rx_hdr_valid, arp_rx_hdr_ready,
                      {arp_rx_dest_mac, arp_rx_src_mac, {TYPE_W{1'b0}}});
            watch_beat(S_ARP, arp_rx_payload_tvalid, arp_rx_payload_tready,
                       {arp_rx_payload_tdata, arp_rx_payload_tkeep,
                        arp_rx_payload_tlast, arp_rx_payload_tuser});
            watch_hdr(S_TX, tx_hdr_valid, tx_hdr_ready, {tx_dest_mac, tx_src_mac, tx_eth_type});
            watch_beat(S_TX, tx_payload_tvalid, tx_payload_tready,
                       {tx_payload_tdata, tx_payload_tkeep, tx_payload_tlast, tx_payload_tuser});
        end
    end

    function automatic int pending();
        int n;
        int s;
        n = 0;
        for (s = 0; s < 3; s++) begin
            n = n + exp_hdr[s].size() + exp_beat[s].size();
        end
        return n;
    endfunction

    // Few idle cycles at the end let a stray valid show up
    task automatic wait_drained();
        do begin
            @(posedge clk);
        end while (pending() != 0);
        repeat (4) @(posedge clk);
    endtask

    task automatic apply_reset();
        logic [5:0] valids;
        @(posedge clk);
        #1;
        rst = 1'b1;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        valids = {ip_rx_hdr_valid, ip_rx_payload_tvalid, arp_rx_hdr_valid,
                  arp_rx_payload_tvalid, tx_hdr_valid, tx_payload_tvalid};
        checks++;
        assert (valids == 6'b0) else begin
            errors++;
            $display("error %s valid outputs after reset: expected %h actual %h",
                     cur_test, 6'b0, valids);
        end
    endtask

    task automatic test_ipv4_rx();
        int f;
        cur_test = "ipv4_rx";
        f = make_frame(16'h0800, 4, PORT_RX);
        send_frame(PORT_RX, f);
        wait_drained();
    endtask

    task automatic test_arp_rx();
        int f;
        cur_test = "arp_rx";
        f = make_frame(16'h0806, 3, PORT_RX);
        send_frame(PORT_RX, f);
        wait_drained();
    endtask

    // IPv6 frame is drained, the IPv4 frame after it still reaches ip_rx
    task automatic test_drop_rx();
        int f;
        int g;
        cur_test = "drop_rx";
        f = make_frame(16'h86dd, 5, PORT_RX);
        g = make_frame(16'h0800, 2, PORT_RX);
        send_frame(PORT_RX, f);
        send_frame(PORT_RX, g);
        wait_drained();
    endtask

    task automatic test_tx_priority();
        int fa;
        int fi;
        cur_test = "tx_priority";
        fa = make_frame(16'h0806, 3, PORT_ARP_TX);
        fi = make_frame(16'h0800, 4, PORT_IP_TX);
        fork
            send_frame(PORT_ARP_TX, fa);
            send_frame(PORT_IP_TX, fi);
        join
        wait_drained();
    endtask

    task automatic test_random_mix();
        logic [TYPE_W-1:0] types [4];
        int rx_ids  [RAND_FRAMES];
        int tx_ids  [RAND_FRAMES];
        int tx_port [RAND_FRAMES];
        int i;
        int j;
        cur_test = "random_mix";
        types = '{16'h0800, 16'h0806, 16'h86dd, 16'h88cc};
        apply_reset();
        for (i = 0; i < RAND_FRAMES; i++) begin
            rx_ids[i]  = make_frame(types[$random(seed) & 3],
                                    1 + (($random(seed) & 32'h7fff) % MAX_LEN), PORT_RX);
            tx_port[i] = ($random(seed) & 1) ? PORT_ARP_TX : PORT_IP_TX;
            tx_ids[i]  = make_frame((tx_port[i] == PORT_ARP_TX) ? 16'h0806 : 16'h0800,
                                    1 + (($random(seed) & 32'h7fff) % MAX_LEN), tx_port[i]);
        end
        random_ready = 1'b1;
        fork
            for (i = 0; i < RAND_FRAMES; i++) begin
                send_frame(PORT_RX, rx_ids[i]);
            end
            for (j = 0; j < RAND_FRAMES; j++) begin
                send_frame(tx_port[j], tx_ids[j]);
            end
        join
        wait_drained();
        random_ready = 1'b0;
    endtask

    initial begin
        rst = 1'b1;
        put_hdr(PORT_RX, '0, 1'b0);
        put_hdr(PORT_ARP_TX, '0, 1'b0);
        put_hdr(PORT_IP_TX, '0, 1'b0);
        put_beat(PORT_RX, '0, 1'b0);
        put_beat(PORT_ARP_TX, '0, 1'b0);
        put_beat(PORT_IP_TX, '0, 1'b0);
        apply_reset();
        test_ipv4_rx();
        test_arp_rx();
        test_drop_rx();
        test_tx_priority();
        test_random_mix();
        $display("Checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * 100);
        $display("Watchdog expired after %0d cycles with frames still outstanding",
                 WATCHDOG_CYCLES);
        $display("Checks %0d, errors %0d", checks, errors);
        $display("Test failed");
        $finish;
    end

endmodule

// File: eth_type_switch.f
verilog/eth_frame_pkg.sv
verilog/eth_route_pkg.sv
verilog/eth_skid_buffer.sv
verilog/eth_rx_classifier.sv
verilog/eth_tx_arbiter.sv
verilog/eth_type_switch.sv
bench/eth_type_switch_tb.sv

// File: Bender.yml
package:
  name: eth_type_switch

sources:
  - verilog/eth_frame_pkg.sv
  - verilog/eth_route_pkg.sv
  - verilog/eth_skid_buffer.sv
  - verilog/eth_rx_classifier.sv
  - verilog/eth_tx_arbiter.sv
  - verilog/eth_type_switch.sv
  - target: simulation
    files:
      - bench/eth_type_switch_tb.sv
